//--- build.f
verilog/net_pkg.sv
verilog/ctrl_pkg.sv
verilog/beat_if.sv
verilog/mac_filter.sv
verilog/beat_fifo.sv
verilog/beat_packer.sv
verilog/net_ctrl_regs.sv
verilog/cpunet_rx.sv
testbench/tb_cpunet_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cpunet_rx testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_cpunet_rx -f build.f -o tb_cpunet_rx

./obj_dir/tb_cpunet_rx 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation finished cleanly"

//--- testbench/tb_cpunet_rx.sv
// Testbench for the CPU network receive path with a packing reference model
`timescale 1ns/10ps
`default_nettype none

module tb_cpunet_rx;

	localparam logic [47:0] CPU_MAC = 48'h02_00_00_00_12_34;
	localparam int LGFIFO = 3;
	localparam int CREDITS = 2;
	// Room for 40 packets of up to 8 beats with stalls several times over
	localparam int MAX_CYCLES = 4000;
	localparam int EXP_DEPTH = 512;

	logic i_clk;
	logic i_reset;
	logic i_rx_valid;
	logic o_rx_ready;
	logic [net_pkg::BEAT_W-1:0] i_rx_data;
	logic [net_pkg::BYTES_W-1:0] i_rx_bytes;
	logic i_rx_last;
	logic o_wide_valid;
	logic i_wide_ready;
	logic [net_pkg::WIDE_W-1:0] o_wide_data;
	logic [net_pkg::WIDE_BYTES_W-1:0] o_wide_bytes;
	logic o_wide_last;
	logic i_reg_stb;
	logic i_reg_we;
	logic [ctrl_pkg::REG_ADDR_W-1:0] i_reg_addr;
	logic [31:0] i_reg_data;
	logic o_reg_ack;
	logic [31:0] o_reg_data;

	// Expected wide words queued at packet start
	logic [net_pkg::WIDE_W-1:0] exp_data [0:EXP_DEPTH-1];
	logic [net_pkg::WIDE_BYTES_W-1:0] exp_bytes [0:EXP_DEPTH-1];
	logic exp_last [0:EXP_DEPTH-1];
	int exp_wr;
	int exp_rd;

	integer seed = 6164;
	string test_name;
	int errors;
	int err_at_start;
	int tests_done;
	int words_taken;
	int reg_reads;
	int cycles;
	int kept_pkts;
	int dropped_pkts;
	logic stall_on;
	logic took;
	logic model_enable;
	logic model_promisc;
	logic reg_check;
	logic [31:0] reg_expect;

	cpunet_rx #(
		.CPU_MAC(CPU_MAC),
		.LGFIFO(LGFIFO),
		.CREDITS(CREDITS)
	) u_cpunet_rx (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_rx_valid(i_rx_valid),
		.o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data),
		.i_rx_bytes(i_rx_bytes),
		.i_rx_last(i_rx_last),
		.o_wide_valid(o_wide_valid),
		.i_wide_ready(i_wide_ready),
		.o_wide_data(o_wide_data),
		.o_wide_bytes(o_wide_bytes),
		.o_wide_last(o_wide_last),
		.i_reg_stb(i_reg_stb),
		.i_reg_we(i_reg_we),
		.i_reg_addr(i_reg_addr),
		.i_reg_data(i_reg_data),
		.o_reg_ack(o_reg_ack),
		.o_reg_data(o_reg_data)
	);

	////////////////////////////////////////
	// Clock and cycle limit
	////////////////////////////////////////
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge i_clk);
			cycles = cycles + 1;
		end
		$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Checks sampled mid-cycle where all is stable
	////////////////////////////////////////
	a_no_extra: assert property (@(negedge i_clk) disable iff (i_reset)
		o_wide_valid |-> (exp_rd != exp_wr))
		else begin
			errors = errors + 1;
			$display("%s: a wide word came out with no packet expected", test_name);
		end

	a_word_data: assert property (@(negedge i_clk) disable iff (i_reset)
		(o_wide_valid && (exp_rd != exp_wr)) |-> (o_wide_data == exp_data[exp_rd]))
		else begin
			errors = errors + 1;
			$display("Fail %s data: expected %h, actual %h", test_name,
				exp_data[exp_rd], o_wide_data);
		end

	a_word_tail: assert property (@(negedge i_clk) disable iff (i_reset)
		(o_wide_valid && (exp_rd != exp_wr)) |->
		({o_wide_last, o_wide_bytes} == {exp_last[exp_rd], exp_bytes[exp_rd]}))
		else begin
			errors = errors + 1;
			$display("Fail %s last/bytes: expected %0b/%0d, actual %0b/%0d", test_name,
				exp_last[exp_rd], exp_bytes[exp_rd], o_wide_last, o_wide_bytes);
		end

	// Stalled word must still be offered, unchanged
	a_hold: assert property (@(negedge i_clk) disable iff (i_reset)
		(o_wide_valid && !i_wide_ready) |=> (o_wide_valid && $stable(o_wide_data)))
		else begin
			errors = errors + 1;
			$display("%s: a stalled wide word was dropped or changed", test_name);
		end

	// Register ack follows every strobe by exactly one cycle
	a_reg_ack: assert property (@(negedge i_clk) disable iff (i_reset)
		o_reg_ack == $past(i_reg_stb))
		else begin
			errors = errors + 1;
			$display("%s: register ack did not follow the strobe by one cycle", test_name);
		end

	a_reg_read: assert property (@(negedge i_clk) disable iff (i_reset)
		(o_reg_ack && reg_check) |-> (o_reg_data == reg_expect))
		else begin
			errors = errors + 1;
			$display("Fail %s register: expected %h, actual %h", test_name,
				reg_expect, o_reg_data);
		end

	////////////////////////////////////////
	// Wide side sink
	////////////////////////////////////////
	// Queue head moves on the edge that takes a word
	initial begin
		forever begin
			@(negedge i_clk);
			took = !i_reset && o_wide_valid && i_wide_ready;
			@(posedge i_clk);
			if (took) begin
				exp_rd = exp_rd + 1;
				words_taken = words_taken + 1;
			end
			#1;
			i_wide_ready = stall_on ? (rand_below(2) == 1) : 1'b1;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		rand_below = int'(r % n);
	endfunction

	// Nonzero XOR in the low bits keeps it off CPU_MAC
	function automatic logic [47:0] other_mac();
		logic [31:0] r;
		r = $random(seed);
		other_mac = CPU_MAC ^ {16'h0, r | 32'h1};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic wait_drain();
		while (exp_rd != exp_wr) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic write_reg(input logic [ctrl_pkg::REG_ADDR_W-1:0] addr,
			input logic [31:0] value);
		i_reg_stb = 1'b1;
		i_reg_we = 1'b1;
		i_reg_addr = addr;
		i_reg_data = value;
		reg_check = 1'b0;
		@(posedge i_clk);
		#1;
		i_reg_stb = 1'b0;
		i_reg_we = 1'b0;
		@(negedge i_clk);
		while (!o_reg_ack)
			@(negedge i_clk);
		@(posedge i_clk);
		#1;
	endtask

	task automatic read_reg(input logic [ctrl_pkg::REG_ADDR_W-1:0] addr,
			input logic [31:0] expected);
		i_reg_stb = 1'b1;
		i_reg_we = 1'b0;
		i_reg_addr = addr;
		reg_expect = expected;
		reg_check = 1'b1;
		@(posedge i_clk);
		#1;
		i_reg_stb = 1'b0;
		@(negedge i_clk);
		while (!o_reg_ack)
			@(negedge i_clk);
		reg_reads = reg_reads + 1;
		@(posedge i_clk);
		#1;
		reg_check = 1'b0;
	endtask

	task automatic set_control(input logic enable, input logic promisc);
		logic [31:0] value;
		value = '0;
		value[ctrl_pkg::CTRL_ENABLE_BIT] = enable;
		value[ctrl_pkg::CTRL_PROMISC_BIT] = promisc;
		write_reg(ctrl_pkg::ADDR_CONTROL, value);
		model_enable = enable;
		model_promisc = promisc;
	endtask

	// Builds one packet, queues its wide words if kept, then drives it
	task automatic send_packet(input logic [47:0] mac, input int nbeats);
		net_pkg::beat_word_u word;
		logic [net_pkg::BEAT_W-1:0] data [0:7];
		logic [net_pkg::BYTES_W-1:0] bytes [0:7];
		logic keep;
		int i;
		int lo;
		int hi;
		for (i = 0; i < nbeats; i++) begin
			word.raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
			if (i == 0)
				word.hdr.dst_mac = mac;
			data[i] = word.raw;
			bytes[i] = 4'd0;
		end
		bytes[nbeats-1] = 4'(rand_below(16));
		keep = model_enable && (model_promisc || (mac == CPU_MAC));
		if (keep)
			kept_pkts = kept_pkts + 1;
		else
			dropped_pkts = dropped_pkts + 1;
		// Pairs go low half first and a lone tail beat leaves the high half zero
		i = 0;
		while (keep && (i < nbeats)) begin
			lo = (bytes[i] == 4'd0) ? 16 : int'(bytes[i]);
			if (i + 1 < nbeats) begin
				hi = (bytes[i+1] == 4'd0) ? 16 : int'(bytes[i+1]);
				exp_data[exp_wr] = {data[i+1], data[i]};
				exp_bytes[exp_wr] = 5'((lo + hi) % 32);
				exp_last[exp_wr] = (i + 2 == nbeats);
				i = i + 2;
			end else begin
				exp_data[exp_wr] = {{net_pkg::BEAT_W{1'b0}}, data[i]};
				exp_bytes[exp_wr] = 5'(lo);
				exp_last[exp_wr] = 1'b1;
				i = i + 1;
			end
			exp_wr = exp_wr + 1;
		end
		for (i = 0; i < nbeats; i++) begin
			i_rx_valid = 1'b1;
			i_rx_data = data[i];
			i_rx_bytes = bytes[i];
			i_rx_last = (i == nbeats - 1);
			@(negedge i_clk);
			while (!o_rx_ready)
				@(negedge i_clk);
			@(posedge i_clk);
			#1;
		end
		i_rx_valid = 1'b0;
		i_rx_last = 1'b0;
		idle_cycles(rand_below(3));
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = errors;
	endtask

	task automatic finish_test();
		tests_done = tests_done + 1;
		$display("Test %s finished with %0d errors", test_name, errors - err_at_start);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		int n;
		i_reset = 1'b1;
		i_rx_valid = 1'b0;
		i_rx_data = '0;
		i_rx_bytes = '0;
		i_rx_last = 1'b0;
		i_wide_ready = 1'b1;
		i_reg_stb = 1'b0;
		i_reg_we = 1'b0;
		i_reg_addr = '0;
		i_reg_data = '0;
		exp_wr = 0;
		exp_rd = 0;
		errors = 0;
		tests_done = 0;
		words_taken = 0;
		reg_reads = 0;
		kept_pkts = 0;
		dropped_pkts = 0;
		stall_on = 1'b0;
		took = 1'b0;
		model_enable = 1'b0;
		model_promisc = 1'b0;
		reg_check = 1'b0;
		reg_expect = '0;
		test_name = "reset";
		repeat (4) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		// Control reads clear out of reset before packets to this CPU
		start_test("keep_own_mac");
		read_reg(ctrl_pkg::ADDR_CONTROL, 32'h0);
		set_control(1'b1, 1'b0);
		for (n = 0; n < 8; n++)
			send_packet(CPU_MAC, 1 + rand_below(8));
		wait_drain();
		finish_test();

		start_test("drop_other_mac");
		for (n = 0; n < 5; n++)
			send_packet(other_mac(), 1 + rand_below(8));
		idle_cycles(2);
		read_reg(ctrl_pkg::ADDR_RX_DROPS, 32'(dropped_pkts));
		finish_test();

		start_test("promiscuous");
		set_control(1'b1, 1'b1);
		for (n = 0; n < 8; n++)
			send_packet(other_mac(), 1 + rand_below(8));
		wait_drain();
		finish_test();

		// Mixed traffic under random back-pressure
		start_test("wide_stalls");
		set_control(1'b1, 1'b0);
		stall_on = 1'b1;
		for (n = 0; n < 12; n++)
			send_packet((rand_below(3) == 0) ? other_mac() : CPU_MAC, 1 + rand_below(8));
		wait_drain();
		stall_on = 1'b0;
		finish_test();

		start_test("registers");
		idle_cycles(2);
		read_reg(ctrl_pkg::ADDR_CONTROL, 32'h2);
		read_reg(ctrl_pkg::ADDR_MAC_HI, {16'h0, CPU_MAC[47:32]});
		read_reg(ctrl_pkg::ADDR_MAC_LO, CPU_MAC[31:0]);
		read_reg(ctrl_pkg::ADDR_RX_PKTS, 32'(kept_pkts));
		write_reg(ctrl_pkg::ADDR_RX_PKTS, 32'h0);
		kept_pkts = 0;
		read_reg(ctrl_pkg::ADDR_RX_PKTS, 32'h0);
		finish_test();

		// Receive path off drops the own MAC too
		start_test("disabled");
		set_control(1'b0, 1'b0);
		for (n = 0; n < 6; n++)
			send_packet(CPU_MAC, 1 + rand_below(8));
		wait_drain();
		idle_cycles(2);
		read_reg(ctrl_pkg::ADDR_RX_DROPS, 32'(dropped_pkts));
		read_reg(ctrl_pkg::ADDR_RX_PKTS, 32'h0);
		finish_test();

		$display("%0d tests, %0d words taken, %0d register reads, %0d errors",
			tests_done, words_taken, reg_reads, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpunet_rx.sv
// CPU network receive top, filter then buffer then pack to wide words
`timescale 1ns/10ps
`default_nettype none

module cpunet_rx #(
	parameter logic [47:0] CPU_MAC = 48'h02_00_00_00_12_34,
	parameter int LGFIFO = 3,
	parameter int CREDITS = 2
) (
	input wire i_clk,
	input wire i_reset,
	// Narrow receive stream
	input wire i_rx_valid,
	output logic o_rx_ready,
	input wire [net_pkg::BEAT_W-1:0] i_rx_data,
	input wire [net_pkg::BYTES_W-1:0] i_rx_bytes,
	input wire i_rx_last,
	// Wide output stream
	output logic o_wide_valid,
	input wire i_wide_ready,
	output logic [net_pkg::WIDE_W-1:0] o_wide_data,
	output logic [net_pkg::WIDE_BYTES_W-1:0] o_wide_bytes,
	output logic o_wide_last,
	// Register port
	input wire i_reg_stb,
	input wire i_reg_we,
	input wire [ctrl_pkg::REG_ADDR_W-1:0] i_reg_addr,
	input wire [31:0] i_reg_data,
	output logic o_reg_ack,
	output logic [31:0] o_reg_data
);
	logic promisc;
	logic enable;
	logic pkt_accepted;
	logic pkt_dropped;

	// Filter to FIFO, then FIFO to packer
	beat_if link_in ();
	beat_if link_out ();

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////
	mac_filter #(
		.CPU_MAC(CPU_MAC),
		.LGFIFO(LGFIFO)
	) u_mac_filter (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_rx_valid(i_rx_valid),
		.o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data),
		.i_rx_bytes(i_rx_bytes),
		.i_rx_last(i_rx_last),
		.i_promisc(promisc),
		.i_enable(enable),
		.link_in(link_in),
		.o_pkt_accepted(pkt_accepted),
		.o_pkt_dropped(pkt_dropped)
	);

	beat_fifo #(
		.LGFIFO(LGFIFO),
		.CREDITS(CREDITS)
	) u_beat_fifo (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.link_in(link_in),
		.link_out(link_out)
	);

	beat_packer #(
		.CREDITS(CREDITS)
	) u_beat_packer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.link_out(link_out),
		.o_wide_valid(o_wide_valid),
		.i_wide_ready(i_wide_ready),
		.o_wide_data(o_wide_data),
		.o_wide_bytes(o_wide_bytes),
		.o_wide_last(o_wide_last)
	);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////
	net_ctrl_regs #(
		.CPU_MAC(CPU_MAC)
	) u_net_ctrl_regs (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_reg_stb(i_reg_stb),
		.i_reg_we(i_reg_we),
		.i_reg_addr(i_reg_addr),
		.i_reg_data(i_reg_data),
		.o_reg_ack(o_reg_ack),
		.o_reg_data(o_reg_data),
		.i_pkt_accepted(pkt_accepted),
		.i_pkt_dropped(pkt_dropped),
		.o_promisc(promisc),
		.o_enable(enable)
	);

endmodule

`default_nettype wire

//--- verilog/net_ctrl_regs.sv
// Control register block with enable bits, MAC readback and packet counters
`timescale 1ns/10ps
`default_nettype none

module net_ctrl_regs #(
	parameter logic [47:0] CPU_MAC = 48'h02_00_00_00_12_34
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_reg_stb,
	input wire i_reg_we,
	input wire [ctrl_pkg::REG_ADDR_W-1:0] i_reg_addr,
	input wire [31:0] i_reg_data,
	output logic o_reg_ack,
	output logic [31:0] o_reg_data,
	input wire i_pkt_accepted,
	input wire i_pkt_dropped,
	output logic o_promisc,
	output logic o_enable
);
	logic wr_ctrl;
	logic clr_drops;
	logic clr_pkts;
	logic [31:0] rx_drops;
	logic [31:0] rx_pkts;

	////////////////////////////////////////
	// Write decode
	////////////////////////////////////////
	assign wr_ctrl = i_reg_stb && i_reg_we && (i_reg_addr == ctrl_pkg::ADDR_CONTROL);
	assign clr_drops = i_reg_stb && i_reg_we && (i_reg_addr == ctrl_pkg::ADDR_RX_DROPS);
	assign clr_pkts = i_reg_stb && i_reg_we && (i_reg_addr == ctrl_pkg::ADDR_RX_PKTS);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_promisc <= 1'b0;
			o_enable <= 1'b0;
		end else if (wr_ctrl) begin
			o_promisc <= i_reg_data[ctrl_pkg::CTRL_PROMISC_BIT];
			o_enable <= i_reg_data[ctrl_pkg::CTRL_ENABLE_BIT];
		end
	end

	// A clear write wins over a same-cycle event
	always_ff @(posedge i_clk) begin
		if (i_reset || clr_drops)
			rx_drops <= '0;
		else if (i_pkt_dropped)
			rx_drops <= rx_drops + 32'd1;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset || clr_pkts)
			rx_pkts <= '0;
		else if (i_pkt_accepted)
			rx_pkts <= rx_pkts + 32'd1;
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////
	// Ack one cycle after every strobe
	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_reg_ack <= 1'b0;
		else
			o_reg_ack <= i_reg_stb;
	end

	always_ff @(posedge i_clk) begin
		if (i_reg_stb) begin
			o_reg_data <= '0;
			case (i_reg_addr)
			ctrl_pkg::ADDR_CONTROL: begin
				o_reg_data[ctrl_pkg::CTRL_PROMISC_BIT] <= o_promisc;
				o_reg_data[ctrl_pkg::CTRL_ENABLE_BIT] <= o_enable;
			end
			ctrl_pkg::ADDR_MAC_HI: o_reg_data[15:0] <= CPU_MAC[47:32];
			ctrl_pkg::ADDR_MAC_LO: o_reg_data <= CPU_MAC[31:0];
			ctrl_pkg::ADDR_RX_DROPS: o_reg_data <= rx_drops;
			ctrl_pkg::ADDR_RX_PKTS: o_reg_data <= rx_pkts;
			default: o_reg_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/beat_packer.sv
// Beat packer that joins narrow beat pairs into wide words for the outside
`timescale 1ns/10ps
`default_nettype none

module beat_packer #(
	parameter int CREDITS = 2
) (
	input wire i_clk,
	input wire i_reset,
	beat_if.receiver link_out,
	output logic o_wide_valid,
	input wire i_wide_ready,
	output logic [net_pkg::WIDE_W-1:0] o_wide_data,
	output logic [net_pkg::WIDE_BYTES_W-1:0] o_wide_bytes,
	output logic o_wide_last
);
	localparam int QW = $clog2(CREDITS + 1);
	localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;

	// Small circular store, one slot per credit
	net_pkg::beat_t q [0:CREDITS-1];
	logic [PW-1:0] rd_idx;
	logic [PW-1:0] wr_idx;
	logic [QW-1:0] count;
	logic [QW-1:0] ret_cnt;
	logic [QW-1:0] freed;
	net_pkg::beat_t head;
	net_pkg::beat_t nxt;
	logic lone;
	logic pair;
	logic take;
	logic ret_now;
	logic [net_pkg::WIDE_BYTES_W-1:0] lo_bytes;
	logic [net_pkg::WIDE_BYTES_W-1:0] hi_bytes;

	// Index advance with wrap at CREDITS
	function automatic logic [PW-1:0] wrap_add(input logic [PW-1:0] idx,
			input logic [1:0] step);
		logic [PW:0] sum;
		sum = {1'b0, idx} + (PW+1)'(step);
		if (sum >= (PW+1)'(CREDITS))
			sum = sum - (PW+1)'(CREDITS);
		return sum[PW-1:0];
	endfunction

	////////////////////////////////////////
	// Word assembly
	////////////////////////////////////////
	assign head = q[rd_idx];
	assign nxt = q[wrap_add(rd_idx, 2'd1)];
	// Packet ending in the low half
	assign lone = (count != 0) && head.last;
	assign pair = (count >= QW'(2)) && !head.last;
	assign o_wide_valid = lone || pair;
	assign o_wide_data = lone ? {{net_pkg::BEAT_W{1'b0}}, head.data} : {nxt.data, head.data};
	assign o_wide_last = lone || nxt.last;
	// Zero count means 16 bytes per beat
	assign lo_bytes = {(head.bytes == '0), head.bytes};
	assign hi_bytes = {(nxt.bytes == '0), nxt.bytes};
	// Sum wraps to 0 for a full 32-byte word
	assign o_wide_bytes = lone ? lo_bytes : (lo_bytes + hi_bytes);

	assign take = o_wide_valid && i_wide_ready;
	assign freed = !take ? QW'(0) : (lone ? QW'(1) : QW'(2));

	////////////////////////////////////////
	// Store and credit return
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (link_out.valid)
			q[wr_idx] <= link_out.beat;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rd_idx <= '0;
			wr_idx <= '0;
			count <= '0;
		end else begin
			rd_idx <= wrap_add(rd_idx, 2'(freed));
			wr_idx <= wrap_add(wr_idx, {1'b0, link_out.valid});
			count <= count + QW'(link_out.valid) - freed;
		end
	end

	// A pair frees two slots, so credits drain one per cycle
	assign ret_now = (ret_cnt != 0);
	assign link_out.credit = ret_now;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			ret_cnt <= '0;
		else
			ret_cnt <= ret_cnt + freed - QW'(ret_now);
	end

	// FIFO credits never overrun the store
	assert property (@(posedge i_clk) disable iff (i_reset)
		link_out.valid |-> (count < QW'(CREDITS)));

	// Offered word holds until taken
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wide_valid && !i_wide_ready) |=> (o_wide_valid && $stable(o_wide_data)));

endmodule

`default_nettype wire

//--- verilog/beat_fifo.sv
// Beat FIFO that buffers filtered beats and sends them on under packer credits
`timescale 1ns/10ps
`default_nettype none

module beat_fifo #(
	parameter int LGFIFO = 3,
	parameter int CREDITS = 2
) (
	input wire i_clk,
	input wire i_reset,
	beat_if.receiver link_in,
	beat_if.sender link_out
);
	localparam int DEPTH = 2**LGFIFO;
	localparam int OCW = $clog2(CREDITS + 1);

	net_pkg::beat_t mem [0:DEPTH-1];
	// Extra MSB tells full from empty
	logic [LGFIFO:0] wr_ptr;
	logic [LGFIFO:0] rd_ptr;
	logic [LGFIFO:0] fill;
	logic empty;
	logic full;
	logic pop;
	logic [OCW-1:0] out_credits;

	////////////////////////////////////////
	// Status and pop
	////////////////////////////////////////
	assign fill = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);
	assign full = (fill == (LGFIFO+1)'(DEPTH));
	// Head goes out as soon as the packer has room
	assign pop = !empty && (out_credits != 0);
	assign link_out.valid = pop;
	assign link_out.beat = mem[rd_ptr[LGFIFO-1:0]];
	// Freed slot goes straight back upstream
	assign link_in.credit = pop;

	always_ff @(posedge i_clk) begin
		if (link_in.valid)
			mem[wr_ptr[LGFIFO-1:0]] <= link_in.beat;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + (LGFIFO+1)'(link_in.valid);
			rd_ptr <= rd_ptr + (LGFIFO+1)'(pop);
		end
	end

	// Packer credits with one per beat slot downstream
	always_ff @(posedge i_clk) begin
		if (i_reset)
			out_credits <= OCW'(CREDITS);
		else
			out_credits <= out_credits - OCW'(pop) + OCW'(link_out.credit);
	end

	// Upstream credit count must keep pushes off a full buffer
	assert property (@(posedge i_clk) disable iff (i_reset)
		link_in.valid |-> !full);

	// Packer never hands back more credits than it was given
	assert property (@(posedge i_clk) disable iff (i_reset)
		out_credits <= OCW'(CREDITS));

endmodule

`default_nettype wire

//--- verilog/mac_filter.sv
// MAC filter that keeps packets for this CPU and forwards them on a credit link
`timescale 1ns/10ps
`default_nettype none

module mac_filter #(
	parameter logic [47:0] CPU_MAC = 48'h02_00_00_00_12_34,
	parameter int LGFIFO = 3
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_rx_valid,
	output logic o_rx_ready,
	input wire [net_pkg::BEAT_W-1:0] i_rx_data,
	input wire [net_pkg::BYTES_W-1:0] i_rx_bytes,
	input wire i_rx_last,
	input wire i_promisc,
	input wire i_enable,
	beat_if.sender link_in,
	output logic o_pkt_accepted,
	output logic o_pkt_dropped
);
	// Credit counter reaches the full FIFO depth
	localparam int CW = LGFIFO + 1;
	localparam logic [CW-1:0] DEPTH = CW'(2**LGFIFO);

	net_pkg::beat_word_u rx_word;
	logic in_pkt;
	logic keep_pkt;
	logic first_keep;
	logic keep_now;
	logic accept;
	logic spend;
	logic [CW-1:0] credits;

	////////////////////////////////////////
	// Keep or drop decision
	////////////////////////////////////////
	assign rx_word = i_rx_data;
	// Only meaningful on the first beat
	assign first_keep = i_enable && (i_promisc || (rx_word.hdr.dst_mac == CPU_MAC));
	assign keep_now = in_pkt ? keep_pkt : first_keep;
	// Dropped beats never wait on credits
	assign o_rx_ready = !keep_now || (credits != 0);
	assign accept = i_rx_valid && o_rx_ready;
	assign spend = accept && keep_now;

	// Decision held from first beat until last
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			in_pkt <= 1'b0;
			keep_pkt <= 1'b0;
		end else if (accept) begin
			in_pkt <= !i_rx_last;
			if (!in_pkt)
				keep_pkt <= first_keep;
		end
	end

	////////////////////////////////////////
	// Credits and forwarding
	////////////////////////////////////////
	// Spent at accept and covers valid one cycle later
	always_ff @(posedge i_clk) begin
		if (i_reset)
			credits <= DEPTH;
		else
			credits <= credits - CW'(spend) + CW'(link_in.credit);
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			link_in.valid <= 1'b0;
		else
			link_in.valid <= spend;
	end

	always_ff @(posedge i_clk) begin
		link_in.beat.data <= rx_word.raw;
		link_in.beat.bytes <= i_rx_bytes;
		link_in.beat.last <= i_rx_last;
	end

	// Event pulses for the packet counters
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_pkt_accepted <= 1'b0;
			o_pkt_dropped <= 1'b0;
		end else begin
			o_pkt_accepted <= accept && i_rx_last && keep_now;
			o_pkt_dropped <= accept && i_rx_last && !keep_now;
		end
	end

	// A send at zero credits or an extra returned credit pushes the count past the depth
	assert property (@(posedge i_clk) disable iff (i_reset)
		credits <= DEPTH);

endmodule

`default_nettype wire

//--- verilog/beat_if.sv
// Beat link interface carrying narrow beats forward and credits back
`timescale 1ns/10ps
`default_nettype none

interface beat_if;

	// Beat present this cycle, one credit spent
	logic valid;
	net_pkg::beat_t beat;
	// One slot freed at the receiving end
	logic credit;

	////////////////////////////////////////
	// Link ends
	////////////////////////////////////////
	modport sender (
		output valid,
		output beat,
		input credit
	);

	modport receiver (
		input valid,
		input beat,
		output credit
	);

endinterface

`default_nettype wire

//--- verilog/ctrl_pkg.sv
// Control register package with register addresses and control bit positions
`default_nettype none

package ctrl_pkg;

	// Register port address width
	localparam int REG_ADDR_W = 3;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////
	// Promiscuous and enable bits
	localparam logic [REG_ADDR_W-1:0] ADDR_CONTROL = 3'd0;
	// MAC readback, top 16 bits then low 32 bits
	localparam logic [REG_ADDR_W-1:0] ADDR_MAC_HI = 3'd1;
	localparam logic [REG_ADDR_W-1:0] ADDR_MAC_LO = 3'd2;
	// Packet counters, cleared by any write
	localparam logic [REG_ADDR_W-1:0] ADDR_RX_DROPS = 3'd3;
	localparam logic [REG_ADDR_W-1:0] ADDR_RX_PKTS = 3'd4;

	// Control register bit positions
	localparam int CTRL_PROMISC_BIT = 0;
	localparam int CTRL_ENABLE_BIT = 1;

endpackage

`default_nettype wire

//--- verilog/net_pkg.sv
// Network beat package with beat widths, the beat record and the header view
`default_nettype none

package net_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	// Bytes per narrow beat
	localparam int PKT_BYTES = 16;
	// Narrow byte count, 0 stands for a full beat
	localparam int BYTES_W = $clog2(PKT_BYTES);
	localparam int BEAT_W = PKT_BYTES * 8;
	// Two narrow beats per wide word
	localparam int WIDE_W = 2 * BEAT_W;
	localparam int WIDE_BYTES_W = BYTES_W + 1;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	// One narrow beat as it moves between blocks
	typedef struct packed {
		logic [BEAT_W-1:0] data;
		logic [BYTES_W-1:0] bytes;
		logic last;
	} beat_t;

	// First beat of a frame, destination in the top bits
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [15:0] ethertype;
		logic [15:0] rest;
	} eth_hdr_t;

	// Header fields on the first beat, raw payload after it
	typedef union packed {
		eth_hdr_t hdr;
		logic [BEAT_W-1:0] raw;
	} beat_word_u;

endpackage

`default_nettype wire
